//--- compile.f
rtl/dbg_cpu_pkg.sv
rtl/dbg_burst_ctrl.sv
rtl/dbg_spr_bridge.sv
rtl/spr_bank.sv
rtl/dbg_cpu_top.sv
tb/tb_dbg_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass is decided on the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dbg_cpu -f compile.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "All checks passed" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

//--- tb/tb_dbg_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_cpu;

  import dbg_cpu_pkg::*;

  //////////////////////////////
  // Setup
  //////////////////////////////

  localparam int SPR_COUNT = 16;
  localparam int SPR_WAIT  = 2;
  localparam int N_ROWS    = 16;

  // TCK cycles allowed for any single wait
  localparam int WAIT_LIMIT = 200;

  // One command of the stimulus table
  typedef struct packed {
    spr_addr_t  addr;
    burst_len_t len;
    logic       write;
    logic       rnd;
    logic       stray;
    spr_data_t  seed;
  } row_t;

  logic       tck_i     = 1'b0;
  logic       cpu_clk_i = 1'b0;
  logic       rst_i;
  burst_cmd_t cmd_i;
  logic       cmd_stb_i;
  spr_data_t  wr_data_i;
  logic       busy_o;
  logic       word_done_o;
  spr_data_t  rd_data_o;

  row_t       stim [N_ROWS];
  // Model of the register bank
  spr_data_t  shadow [SPR_COUNT];
  // word_done_o pulses seen so far
  int         done_cnt;

  // CPU clock of 10 ns and TCK of 34 ns
  always #5 cpu_clk_i = ~cpu_clk_i;
  always #17 tck_i = ~tck_i;

  dbg_cpu_top #(
    .SPR_COUNT (SPR_COUNT),
    .SPR_WAIT  (SPR_WAIT)
  ) dbg_cpu_top_inst (
    .tck_i       (tck_i),
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_i),
    .cmd_stb_i   (cmd_stb_i),
    .wr_data_i   (wr_data_i),
    .busy_o      (busy_o),
    .word_done_o (word_done_o),
    .rd_data_o   (rd_data_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Checks failed");
    $fatal(1, "wait timed out");
  endtask

  // Falling TCK edge where outputs are stable and inputs change
  task automatic next_tck_edge();
    @(negedge tck_i);
    if (word_done_o) begin
      done_cnt++;
    end
  endtask

  // Seed plus word index or a random word
  function automatic spr_data_t make_write_word(input row_t r, input int k);
    if (r.rnd) begin
      return $urandom;
    end
    return r.seed + k;
  endfunction

  // Bank index of word k with the upper address bits aliased
  function automatic int bank_index(input row_t r, input int k);
    logic [31:0] word_addr;
    word_addr = r.addr + 32'(4 * k);
    return (word_addr >> 2) % SPR_COUNT;
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  // addr, len, write, rnd, stray strobe, seed
  task automatic fill_table();
    stim[0]  = '{32'h0000_0020, 8'd1,  1'b0, 1'b0, 1'b0, 32'h0};
    stim[1]  = '{32'h0000_0000, 8'd4,  1'b0, 1'b0, 1'b0, 32'h0};
    stim[2]  = '{32'h0000_0014, 8'd1,  1'b1, 1'b0, 1'b0, 32'ha5a5_0001};
    stim[3]  = '{32'h0000_0014, 8'd1,  1'b0, 1'b0, 1'b0, 32'h0};
    stim[4]  = '{32'h0000_0100, 8'd6,  1'b1, 1'b0, 1'b0, 32'h1000_0000};
    stim[5]  = '{32'h0000_0100, 8'd6,  1'b0, 1'b0, 1'b0, 32'h0};
    // Word index SPR_COUNT+3 read back at index 3
    stim[6]  = '{32'h0000_004c, 8'd1,  1'b1, 1'b0, 1'b0, 32'hcafe_0013};
    stim[7]  = '{32'h0000_000c, 8'd1,  1'b0, 1'b0, 1'b0, 32'h0};
    // Stray strobes while busy
    stim[8]  = '{32'h0000_0030, 8'd4,  1'b1, 1'b0, 1'b1, 32'h2222_0000};
    stim[9]  = '{32'h0000_0030, 8'd4,  1'b0, 1'b0, 1'b1, 32'h0};
    // Random bursts where the first wraps the bank
    stim[10] = '{32'h0000_0038, 8'd5,  1'b1, 1'b1, 1'b0, 32'h0};
    stim[11] = '{32'h0000_0008, 8'd3,  1'b1, 1'b1, 1'b0, 32'h0};
    stim[12] = '{32'h0000_0000, 8'd16, 1'b0, 1'b0, 1'b0, 32'h0};
    // Zero length moves one word
    stim[13] = '{32'h0000_001c, 8'd0,  1'b1, 1'b1, 1'b0, 32'h0};
    stim[14] = '{32'h0000_001c, 8'd1,  1'b0, 1'b0, 1'b0, 32'h0};
    stim[15] = '{32'h0000_0040, 8'd16, 1'b0, 1'b0, 1'b0, 32'h0};
  endtask

  //////////////////////////////
  // One command
  //////////////////////////////

  task automatic run_row(input row_t r);
    int        n;
    int        start_cnt;
    int        waited;
    spr_data_t wdata;
    n = (r.len == 8'd0) ? 1 : {24'd0, r.len};
    start_cnt = done_cnt;
    // First write word must be ready when the controller issues it
    if (r.write) begin
      wdata = make_write_word(r, 0);
      shadow[bank_index(r, 0)] = wdata;
      wr_data_i = wdata;
    end
    cmd_i.addr  = r.addr;
    cmd_i.len   = r.len;
    cmd_i.write = r.write;
    cmd_stb_i   = 1'b1;
    next_tck_edge();
    cmd_stb_i = 1'b0;
    check_value("busy_o", {31'd0, busy_o}, 32'd1);
    for (int k = 0; k < n; k++) begin
      waited = 0;
      do begin
        next_tck_edge();
        waited++;
      end while (!word_done_o && waited < WAIT_LIMIT);
      if (!word_done_o) begin
        report_timeout("word_done_o");
      end
      if (!r.write) begin
        check_value("rd_data_o", rd_data_o, shadow[bank_index(r, k)]);
      end else if (k + 1 < n) begin
        wdata = make_write_word(r, k + 1);
        shadow[bank_index(r, k + 1)] = wdata;
        wr_data_i = wdata;
      end
      // A command in the middle of a burst must be dropped
      if (r.stray && k == 0 && n > 1) begin
        check_value("busy_o", {31'd0, busy_o}, 32'd1);
        cmd_i.addr  = 32'h0000_0000;
        cmd_i.len   = 8'd9;
        cmd_i.write = 1'b1;
        cmd_stb_i   = 1'b1;
        next_tck_edge();
        cmd_stb_i = 1'b0;
      end
    end
    // Busy falls one TCK cycle after the last word
    waited = 0;
    while (busy_o && waited < WAIT_LIMIT) begin
      next_tck_edge();
      waited++;
    end
    if (busy_o) begin
      report_timeout("busy_o to fall");
    end
    check_value("busy_o fall delay", waited, 32'd1);
    // Quiet window with no further pulses allowed
    repeat (10) begin
      next_tck_edge();
    end
    check_value("word_done_o count", done_cnt - start_cnt, n);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h79fd_d4e9));
    rst_i     = 1'b1;
    cmd_i     = '0;
    cmd_stb_i = 1'b0;
    wr_data_i = '0;
    done_cnt  = 0;
    for (int i = 0; i < SPR_COUNT; i++) begin
      shadow[i] = '0;
    end
    fill_table();
    repeat (5) @(posedge cpu_clk_i);
    @(negedge tck_i);
    rst_i = 1'b0;
    next_tck_edge();
    // Idle outputs after reset
    check_value("busy_o", {31'd0, busy_o}, 32'd0);
    check_value("word_done_o", {31'd0, word_done_o}, 32'd0);
    check_value("rd_data_o", rd_data_o, 32'd0);
    for (int i = 0; i < N_ROWS; i++) begin
      run_row(stim[i]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/dbg_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cpu_top #(
  parameter int SPR_COUNT = 16,
  parameter int SPR_WAIT  = 2
) (
  input  wire                          tck_i,
  input  wire                          cpu_clk_i,
  input  wire                          rst_i,
  input  wire dbg_cpu_pkg::burst_cmd_t cmd_i,
  input  wire                          cmd_stb_i,
  input  wire dbg_cpu_pkg::spr_data_t  wr_data_i,
  output logic                         busy_o,
  output logic                         word_done_o,
  output dbg_cpu_pkg::spr_data_t       rd_data_o
);

  import dbg_cpu_pkg::*;

  //////////////////////////////
  // Interconnect
  //////////////////////////////

  // Controller to bridge, TCK domain
  spr_addr_t dbg_addr;
  spr_data_t dbg_wdata;
  logic      dbg_stb;
  logic      dbg_rd_wrn;
  logic      dbg_rdy;
  spr_data_t dbg_rdata;

  // Bridge to bank, CPU domain
  spr_req_t  spr_req;
  logic      cpu_stb;
  logic      cpu_ack;
  spr_data_t cpu_rdata;

  //////////////////////////////
  // Blocks
  //////////////////////////////

  // Splits bursts into word accesses
  dbg_burst_ctrl dbg_burst_ctrl_inst (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .cmd_i        (cmd_i),
    .cmd_stb_i    (cmd_stb_i),
    .wr_data_i    (wr_data_i),
    .busy_o       (busy_o),
    .word_done_o  (word_done_o),
    .rd_data_o    (rd_data_o),
    .dbg_addr_o   (dbg_addr),
    .dbg_data_o   (dbg_wdata),
    .dbg_stb_o    (dbg_stb),
    .dbg_rd_wrn_o (dbg_rd_wrn),
    .dbg_rdy_i    (dbg_rdy),
    .dbg_data_i   (dbg_rdata)
  );

  // Clock crossing and SPR bus cycle
  dbg_spr_bridge dbg_spr_bridge_inst (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .dbg_addr_i   (dbg_addr),
    .dbg_data_i   (dbg_wdata),
    .dbg_stb_i    (dbg_stb),
    .dbg_rd_wrn_i (dbg_rd_wrn),
    .dbg_rdy_o    (dbg_rdy),
    .dbg_data_o   (dbg_rdata),
    .cpu_clk_i    (cpu_clk_i),
    .spr_req_o    (spr_req),
    .cpu_stb_o    (cpu_stb),
    .cpu_data_i   (cpu_rdata),
    .cpu_ack_i    (cpu_ack)
  );

  // Register bank in place of the CPU
  spr_bank #(
    .SPR_COUNT (SPR_COUNT),
    .SPR_WAIT  (SPR_WAIT)
  ) spr_bank_inst (
    .cpu_clk_i  (cpu_clk_i),
    .rst_i      (rst_i),
    .spr_req_i  (spr_req),
    .cpu_stb_i  (cpu_stb),
    .cpu_ack_o  (cpu_ack),
    .cpu_data_o (cpu_rdata)
  );

endmodule

`default_nettype wire

//--- rtl/spr_bank.sv
`timescale 1ns/1ps
`default_nettype none

module spr_bank #(
  parameter int SPR_COUNT = 16,
  parameter int SPR_WAIT  = 2
) (
  input  wire                         cpu_clk_i,
  input  wire                         rst_i,
  input  wire dbg_cpu_pkg::spr_req_t  spr_req_i,
  input  wire                         cpu_stb_i,
  output logic                        cpu_ack_o,
  output dbg_cpu_pkg::spr_data_t      cpu_data_o
);

  import dbg_cpu_pkg::*;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Word index bits, SPR_COUNT is a power of two
  localparam int IDX_W = (SPR_COUNT < 2) ? 1 : $clog2(SPR_COUNT);

  // Wait counter must hold SPR_WAIT
  localparam int CNT_W = (SPR_WAIT < 1) ? 1 : $clog2(SPR_WAIT + 1);

  localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(SPR_WAIT);

  //////////////////////////////
  // Storage and decode
  //////////////////////////////

  spr_data_t        regs [SPR_COUNT];

  // Word address, upper bits dropped so addresses alias
  logic [IDX_W-1:0] idx;

  // Cycles the current strobe has been waiting
  logic [CNT_W-1:0] wait_cnt;

  assign idx = spr_req_i.addr[2 +: IDX_W];

  //////////////////////////////
  // Acknowledge timing
  //////////////////////////////

  // With SPR_WAIT of 0 this is a same cycle ack
  assign cpu_ack_o = cpu_stb_i & (wait_cnt == WAIT_LAST);

  // Count from the first strobe cycle, restart after each ack
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_cnt <= '0;
    end else if (!cpu_stb_i || cpu_ack_o) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + CNT_W'(1);
    end
  end

  //////////////////////////////
  // Register array
  //////////////////////////////

  // Bank reads back zero after reset
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < SPR_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (cpu_ack_o && spr_req_i.we) begin
      // Write lands on the ack cycle
      regs[idx] <= spr_req_i.wdata;
    end
  end

  // Read path, sampled by the bridge on ack
  assign cpu_data_o = regs[idx];

endmodule

`default_nettype wire

//--- rtl/dbg_spr_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_spr_bridge (
  // Debug side, TCK domain
  input  wire                         tck_i,
  input  wire                         rst_i,
  input  wire dbg_cpu_pkg::spr_addr_t dbg_addr_i,
  input  wire dbg_cpu_pkg::spr_data_t dbg_data_i,
  input  wire                         dbg_stb_i,
  input  wire                         dbg_rd_wrn_i,
  output logic                        dbg_rdy_o,
  output dbg_cpu_pkg::spr_data_t      dbg_data_o,

  // SPR bus side, CPU domain
  input  wire                         cpu_clk_i,
  output dbg_cpu_pkg::spr_req_t       spr_req_o,
  output logic                        cpu_stb_o,
  input  wire dbg_cpu_pkg::spr_data_t cpu_data_i,
  input  wire                         cpu_ack_i
);

  import dbg_cpu_pkg::*;

  //////////////////////////////
  // Holding registers
  //////////////////////////////

  // Request held stable while the CPU side works on it
  spr_req_t  req_q;

  // Read data captured in the CPU domain
  spr_data_t rdata_q;

  // Start toggle, TCK domain
  logic      str_tgl;

  // Ready toggle, CPU domain
  logic      rdy_tgl;

  // Ready toggle brought into TCK
  logic      rdy_tff1;
  logic      rdy_tff2;
  logic      rdy_tff2_q;

  // Start toggle brought into CPU clock
  logic      str_cff1;
  logic      str_cff2;
  logic      str_cff2_q;

  // Access accepted in TCK
  logic      accept;

  // New request seen in the CPU domain
  logic      start_pulse;

  // FSM outputs
  logic      rdata_en;
  logic      rdy_tgl_en;

  bridge_state_t state;
  bridge_state_t state_nxt;

  //////////////////////////////
  // TCK domain
  //////////////////////////////

  assign accept = dbg_stb_i & dbg_rdy_o;

  // Capture the access on an accepted strobe
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      req_q <= '0;
    end else if (accept) begin
      req_q.addr <= dbg_addr_i;
      req_q.we   <= ~dbg_rd_wrn_i;
      // Write data only matters for writes
      if (!dbg_rd_wrn_i) begin
        req_q.wdata <= dbg_data_i;
      end
    end
  end

  // Each accepted access flips the start toggle once
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      str_tgl <= 1'b0;
    end else if (accept) begin
      str_tgl <= ~str_tgl;
    end
  end

  // Ready clears on accept and sets on a returned toggle
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_tff1   <= 1'b0;
      rdy_tff2   <= 1'b0;
      rdy_tff2_q <= 1'b0;
      dbg_rdy_o  <= 1'b1;
    end else begin
      rdy_tff1   <= rdy_tgl;
      rdy_tff2   <= rdy_tff1;
      rdy_tff2_q <= rdy_tff2;
      if (accept) begin
        dbg_rdy_o <= 1'b0;
      end else if (rdy_tff2 != rdy_tff2_q) begin
        dbg_rdy_o <= 1'b1;
      end
    end
  end

  // Held values cross unsynchronized, stable by the time they are used
  assign spr_req_o  = req_q;
  assign dbg_data_o = rdata_q;

  //////////////////////////////
  // CPU domain
  //////////////////////////////

  // Two flop synchronizer plus one for edge detect
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      str_cff1   <= 1'b0;
      str_cff2   <= 1'b0;
      str_cff2_q <= 1'b0;
    end else begin
      str_cff1   <= str_tgl;
      str_cff2   <= str_cff1;
      str_cff2_q <= str_cff2;
    end
  end

  assign start_pulse = (str_cff2 != str_cff2_q);

  // Read data register
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (rdata_en) begin
      rdata_q <= cpu_data_i;
    end
  end

  // Completion toggle back to TCK
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_tgl <= 1'b0;
    end else if (rdy_tgl_en) begin
      rdy_tgl <= ~rdy_tgl;
    end
  end

  //////////////////////////////
  // SPR bus FSM
  //////////////////////////////

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= BRIDGE_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Single cycle access never leaves idle
  always_comb begin
    state_nxt = state;
    case (state)
      BRIDGE_IDLE: begin
        if (start_pulse && !cpu_ack_i) begin
          state_nxt = BRIDGE_TRANSFER;
        end
      end
      BRIDGE_TRANSFER: begin
        if (cpu_ack_i) begin
          state_nxt = BRIDGE_IDLE;
        end
      end
      default: begin
        state_nxt = BRIDGE_IDLE;
      end
    endcase
  end

  // Strobe held until ack, read data latched on ack
  always_comb begin
    cpu_stb_o  = 1'b0;
    rdata_en   = 1'b0;
    rdy_tgl_en = 1'b0;
    case (state)
      BRIDGE_IDLE: begin
        if (start_pulse) begin
          cpu_stb_o  = 1'b1;
          rdy_tgl_en = cpu_ack_i;
          rdata_en   = cpu_ack_i & ~req_q.we;
        end
      end
      BRIDGE_TRANSFER: begin
        cpu_stb_o  = 1'b1;
        rdy_tgl_en = cpu_ack_i;
        rdata_en   = cpu_ack_i & ~req_q.we;
      end
      default: begin
        cpu_stb_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/dbg_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_burst_ctrl (
  input  wire                         tck_i,
  input  wire                         rst_i,

  // Debug command side
  input  wire dbg_cpu_pkg::burst_cmd_t cmd_i,
  input  wire                         cmd_stb_i,
  input  wire dbg_cpu_pkg::spr_data_t wr_data_i,
  output logic                        busy_o,
  output logic                        word_done_o,
  output dbg_cpu_pkg::spr_data_t      rd_data_o,

  // Bridge side, single word accesses
  output dbg_cpu_pkg::spr_addr_t      dbg_addr_o,
  output dbg_cpu_pkg::spr_data_t      dbg_data_o,
  output logic                        dbg_stb_o,
  output logic                        dbg_rd_wrn_o,
  input  wire                         dbg_rdy_i,
  input  wire dbg_cpu_pkg::spr_data_t dbg_data_i
);

  import dbg_cpu_pkg::*;

  //////////////////////////////
  // Burst state
  //////////////////////////////

  burst_state_t state;

  // Address of the next word
  spr_addr_t    addr_q;

  // Words still to be moved, including the one in flight
  burst_len_t   remain_q;

  // Direction of the whole burst
  logic         write_q;

  // Ready from the previous cycle, for edge detect
  logic         rdy_q;
  logic         rdy_rise;

  // Bridge raises ready again once the CPU side has finished
  assign rdy_rise = dbg_rdy_i & ~rdy_q;

  // Bridge leaves reset with ready high, so no false edge
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_q <= 1'b1;
    end else begin
      rdy_q <= dbg_rdy_i;
    end
  end

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state        <= BURST_IDLE;
      addr_q       <= '0;
      remain_q     <= '0;
      write_q      <= 1'b0;
      busy_o       <= 1'b0;
      word_done_o  <= 1'b0;
      rd_data_o    <= '0;
      dbg_addr_o   <= '0;
      dbg_data_o   <= '0;
      dbg_stb_o    <= 1'b0;
      dbg_rd_wrn_o <= 1'b0;
    end else begin
      // Single cycle pulses by default
      word_done_o <= 1'b0;
      dbg_stb_o   <= 1'b0;

      case (state)
        BURST_IDLE: begin
          // Busy drops one cycle after the last word_done
          if (busy_o) begin
            busy_o <= 1'b0;
          end else if (cmd_stb_i) begin
            addr_q   <= cmd_i.addr;
            remain_q <= (cmd_i.len == '0) ? burst_len_t'(1) : cmd_i.len;
            write_q  <= cmd_i.write;
            busy_o   <= 1'b1;
            state    <= BURST_ISSUE;
          end
        end

        BURST_ISSUE: begin
          // Strobe only while the bridge can take it
          if (dbg_rdy_i) begin
            dbg_stb_o    <= 1'b1;
            dbg_addr_o   <= addr_q;
            dbg_rd_wrn_o <= ~write_q;
            // Write word sampled as it goes out
            if (write_q) begin
              dbg_data_o <= wr_data_i;
            end
            state <= BURST_WAIT;
          end
        end

        BURST_WAIT: begin
          // Word complete when ready comes back
          if (rdy_rise) begin
            word_done_o <= 1'b1;
            rd_data_o   <= dbg_data_i;
            addr_q      <= addr_q + 32'd4;
            remain_q    <= remain_q - burst_len_t'(1);
            if (remain_q == burst_len_t'(1)) begin
              state <= BURST_IDLE;
            end else begin
              state <= BURST_ISSUE;
            end
          end
        end

        default: begin
          state <= BURST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/dbg_cpu_pkg.sv
`default_nettype none

package dbg_cpu_pkg;

  //////////////////////////////
  // Bus and data widths
  //////////////////////////////

  // SPR bus address
  typedef logic [31:0] spr_addr_t;

  // SPR data word
  typedef logic [31:0] spr_data_t;

  // Words per burst, zero is taken as one word
  typedef logic [7:0] burst_len_t;

  //////////////////////////////
  // Grouped signals
  //////////////////////////////

  // Debug command as seen by the burst controller
  typedef struct packed {
    spr_addr_t  addr;
    burst_len_t len;
    logic       write;
  } burst_cmd_t;

  // One SPR bus request from the bridge
  typedef struct packed {
    spr_addr_t addr;
    spr_data_t wdata;
    logic      we;
  } spr_req_t;

  //////////////////////////////
  // State machines
  //////////////////////////////

  // Burst controller in the TCK domain
  typedef enum logic [1:0] {
    BURST_IDLE,
    BURST_ISSUE,
    BURST_WAIT
  } burst_state_t;

  // Bridge bus cycle in the CPU domain
  typedef enum logic {
    BRIDGE_IDLE,
    BRIDGE_TRANSFER
  } bridge_state_t;

endpackage

`default_nettype wire
